// File: rvv_lite.f
+incdir+sim
design/rvv_cfg_pkg.sv
design/rvv_isa_pkg.sv
design/rvv_uop_if.sv
design/rvv_cmd_queue.sv
design/rvv_dispatch.sv
design/rvv_lane_alu.sv
design/rvv_retire.sv
design/rvv_vrf.sv
design/rvv_backend.sv
sim/rvv_backend_tb.sv

// File: sim/rvv_ref_model.svh
`ifndef RVV_REF_MODEL_SVH
`define RVV_REF_MODEL_SVH

// Expected vector result and saturation, vs2 is the left operand
function automatic void model_exec(input rvv_op_e op, input logic [VLEN-1:0] vs2_val,
                                   input logic [VLEN-1:0] vs1_val, input logic [ELEN-1:0] imm,
                                   output logic [VLEN-1:0] res, output bit sat);
  int a;
  int b;
  res = '0;
  sat = 1'b0;
  for (int i = 0; i < NUM_LANES; i++) begin
    a = vs2_val[i*ELEN +: ELEN];
    b = vs1_val[i*ELEN +: ELEN];
    case (op)
      OP_VMV_VI: res[i*ELEN +: ELEN] = imm;
      OP_VADD:   res[i*ELEN +: ELEN] = 8'((a + b) % 256);
      OP_VSUB:   res[i*ELEN +: ELEN] = 8'((a - b + 256) % 256);
      OP_VAND:   res[i*ELEN +: ELEN] = 8'(a & b);
      OP_VOR:    res[i*ELEN +: ELEN] = 8'(a | b);
      OP_VXOR:   res[i*ELEN +: ELEN] = 8'(a ^ b);
      OP_VSADDU: res[i*ELEN +: ELEN] = (a + b > 255) ? 8'd255 : 8'(a + b);
      default:   res[i*ELEN +: ELEN] = (a < b) ? 8'd0 : 8'(a - b);
    endcase
    // Lane clamps on unsigned overflow or underflow
    if ((op == OP_VSADDU && a + b > 255) || (op == OP_VSSUBU && a < b)) sat = 1'b1;
  end
endfunction

`endif

// File: sim/rvv_backend_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rvv_backend_tb
  import rvv_cfg_pkg::*, rvv_isa_pkg::*;
();

  localparam int WAIT_LIMIT = 200;

  logic               clk;
  logic               rst_n;
  logic               inst_valid_i;
  logic               inst_ready_o;
  rvv_op_e            inst_op_i;
  logic [VREG_AW-1:0] inst_vd_i;
  logic [VREG_AW-1:0] inst_vs1_i;
  logic [VREG_AW-1:0] inst_vs2_i;
  logic [ELEN-1:0]    inst_imm_i;
  logic               rt_valid_o;
  logic [VREG_AW-1:0] rt_vd_o;
  logic [VLEN-1:0]    rt_data_o;
  logic               vxsat_o;
  logic               vxsat_clr_i;
  logic               idle_o;

  // Model registers and expected retires in acceptance order
  logic [VLEN-1:0]    model_vrf [NUM_VREG];
  logic [VREG_AW-1:0] exp_vd_q [$];
  logic [VLEN-1:0]    exp_data_q [$];
  bit                 exp_sat_q [$];
  bit                 exp_vxsat;
  bit                 saw_full;
  bit                 monitor_on;
  int                 value_errors;
  int                 timeouts;
  event               timeout_ev;

  `include "rvv_ref_model.svh"

  rvv_backend dut0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .inst_valid_i (inst_valid_i),
    .inst_ready_o (inst_ready_o),
    .inst_op_i    (inst_op_i),
    .inst_vd_i    (inst_vd_i),
    .inst_vs1_i   (inst_vs1_i),
    .inst_vs2_i   (inst_vs2_i),
    .inst_imm_i   (inst_imm_i),
    .rt_valid_o   (rt_valid_o),
    .rt_vd_o      (rt_vd_o),
    .rt_data_o    (rt_data_o),
    .vxsat_o      (vxsat_o),
    .vxsat_clr_i  (vxsat_clr_i),
    .idle_o       (idle_o)
  );

  always #10 clk = ~clk;

  task automatic flag_error(input string msg);
    value_errors++;
    $display("ERROR @ %0t: %s", $time, msg);
  endtask

  task automatic report_end();
    $display("Errors: %0d wrong values, %0d timeouts", value_errors, timeouts);
    if (value_errors == 0 && timeouts == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  endtask

  task automatic note_timeout(input string what);
    timeouts++;
    $display("Timeout at %0t: %s", $time, what);
    -> timeout_ev;
  endtask

  initial begin
    @(timeout_ev);
    report_end();
  end

  // Drives 1 ns after a rising edge and returns 1 ns after the accepting edge
  task automatic send_inst(input rvv_op_e op, input logic [VREG_AW-1:0] vd,
                           input logic [VREG_AW-1:0] vs1, input logic [VREG_AW-1:0] vs2,
                           input logic [ELEN-1:0] imm);
    int              cnt;
    logic [VLEN-1:0] res;
    bit              sat;
    inst_valid_i = 1'b1;
    inst_op_i    = op;
    inst_vd_i    = vd;
    inst_vs1_i   = vs1;
    inst_vs2_i   = vs2;
    inst_imm_i   = imm;
    cnt          = 0;
    @(negedge clk);
    while (!inst_ready_o && cnt < WAIT_LIMIT) begin
      cnt++;
      @(negedge clk);
    end
    if (!inst_ready_o) begin
      note_timeout("instruction was never accepted");
    end else begin
      // Accepted at the coming edge
      model_exec(op, model_vrf[vs2], model_vrf[vs1], imm, res, sat);
      model_vrf[vd] = res;
      exp_vd_q.push_back(vd);
      exp_data_q.push_back(res);
      exp_sat_q.push_back(sat);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic wait_idle();
    int cnt;
    inst_valid_i = 1'b0;
    cnt          = 0;
    @(negedge clk);
    while (!idle_o && cnt < WAIT_LIMIT) begin
      cnt++;
      @(negedge clk);
    end
    if (!idle_o) note_timeout("backend did not return to idle");
    @(posedge clk);
    #1;
  endtask

  task automatic pulse_vxsat_clear();
    vxsat_clr_i = 1'b1;
    @(posedge clk);
    #1;
    vxsat_clr_i = 1'b0;
    exp_vxsat   = 1'b0;
    assert (!vxsat_o) else flag_error("vxsat_o still set after clear pulse");
  endtask

  // Retire and sticky flag checks
  always @(negedge clk) begin : retire_check
    logic [VREG_AW-1:0] e_vd;
    logic [VLEN-1:0]    e_data;
    if (monitor_on) begin
      if (!inst_ready_o) saw_full = 1'b1;
      if (rt_valid_o) begin
        assert (exp_vd_q.size() > 0)
          else flag_error($sformatf("retire of v%0d without an expected entry", rt_vd_o));
        if (exp_vd_q.size() > 0) begin
          e_vd   = exp_vd_q.pop_front();
          e_data = exp_data_q.pop_front();
          if (exp_sat_q.pop_front()) exp_vxsat = 1'b1;
          assert (rt_vd_o == e_vd && rt_data_o == e_data)
            else flag_error($sformatf("retire v%0d data %h, expected v%0d data %h",
                                      rt_vd_o, rt_data_o, e_vd, e_data));
        end
      end
      assert (vxsat_o == exp_vxsat)
        else flag_error($sformatf("vxsat_o is %0b, expected %0b", vxsat_o, exp_vxsat));
    end
  end

  initial begin : main_flow
    rvv_op_e            op;
    logic [VREG_AW-1:0] rd;
    logic [VREG_AW-1:0] ra;
    logic [VREG_AW-1:0] rb;
    logic [VREG_AW-1:0] last_vd;
    void'($urandom(13));
    clk          = 1'b0;
    rst_n        = 1'b0;
    inst_valid_i = 1'b0;
    inst_op_i    = OP_VMV_VI;
    inst_vd_i    = '0;
    inst_vs1_i   = '0;
    inst_vs2_i   = '0;
    inst_imm_i   = '0;
    vxsat_clr_i  = 1'b0;
    monitor_on   = 1'b0;
    exp_vxsat    = 1'b0;
    for (int r = 0; r < NUM_VREG; r++) model_vrf[r] = '0;
    repeat (4) @(posedge clk);
    #1 rst_n = 1'b1;
    @(negedge clk);
    assert (idle_o && inst_ready_o) else flag_error("idle_o or inst_ready_o low after reset");
    assert (!rt_valid_o && !vxsat_o) else flag_error("rt_valid_o or vxsat_o high after reset");
    monitor_on = 1'b1;
    @(posedge clk);
    #1;

    // Immediate broadcast into every register
    for (int r = 0; r < NUM_VREG; r++) begin
      send_inst(OP_VMV_VI, VREG_AW'(r), '0, '0, ELEN'($urandom));
    end
    wait_idle();

    // Random logic and wrapping arithmetic with some reads of the last result
    last_vd = '0;
    for (int n = 0; n < 40; n++) begin
      op = rvv_op_e'(int'(OP_VADD) + $urandom_range(4));
      rd = VREG_AW'($urandom);
      ra = VREG_AW'($urandom);
      rb = VREG_AW'($urandom);
      if (n % 3 == 0) ra = last_vd;
      send_inst(op, rd, ra, rb, '0);
      last_vd = rd;
    end
    wait_idle();

    // Clamping vsaddu and then a plain add that keeps the flag
    send_inst(OP_VMV_VI, 3'd1, '0, '0, 8'hf0);
    send_inst(OP_VMV_VI, 3'd2, '0, '0, 8'h20);
    send_inst(OP_VSADDU, 3'd3, 3'd2, 3'd1, '0);
    wait_idle();
    assert (vxsat_o) else flag_error("vxsat_o not set after clamping vsaddu");
    send_inst(OP_VADD, 3'd4, 3'd2, 3'd2, '0);
    wait_idle();
    assert (vxsat_o) else flag_error("vxsat_o dropped on a plain retire");
    pulse_vxsat_clear();

    // Clamping vssubu on 0x20 minus 0xf0
    send_inst(OP_VSSUBU, 3'd5, 3'd1, 3'd2, '0);
    wait_idle();
    assert (vxsat_o) else flag_error("vxsat_o not set after clamping vssubu");
    pulse_vxsat_clear();

    // Saturating ops that stay in range
    send_inst(OP_VSADDU, 3'd6, 3'd2, 3'd2, '0);
    send_inst(OP_VSSUBU, 3'd7, 3'd2, 3'd1, '0);
    wait_idle();
    assert (!vxsat_o) else flag_error("vxsat_o set without any clamp");

    // Long dependent chain on v7 fills the queue
    saw_full = 1'b0;
    for (int n = 0; n < 16; n++) begin
      send_inst(OP_VADD, 3'd7, 3'd1, 3'd7, '0);
    end
    wait_idle();
    assert (saw_full) else flag_error("inst_ready_o never dropped during the chain");
    assert (exp_vd_q.size() == 0)
      else flag_error($sformatf("%0d expected retires missing at idle", exp_vd_q.size()));
    report_end();
  end

endmodule : rvv_backend_tb

`default_nettype wire

// File: design/rvv_backend.sv
`timescale 1ns/1ps
`default_nettype none

module rvv_backend
  import rvv_cfg_pkg::*, rvv_isa_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  input  logic               inst_valid_i,
  output logic               inst_ready_o,
  input  rvv_op_e            inst_op_i,
  input  logic [VREG_AW-1:0] inst_vd_i,
  input  logic [VREG_AW-1:0] inst_vs1_i,
  input  logic [VREG_AW-1:0] inst_vs2_i,
  input  logic [ELEN-1:0]    inst_imm_i,
  output logic               rt_valid_o,
  output logic [VREG_AW-1:0] rt_vd_o,
  output logic [VLEN-1:0]    rt_data_o,
  output logic               vxsat_o,
  input  logic               vxsat_clr_i,
  output logic               idle_o
);

  rvv_inst_t          inst_pkt;
  rvv_inst_t          cmd_inst;
  logic               cmd_valid;
  logic               cmd_pop;
  logic               q_empty;
  logic               dp_busy;
  logic [VREG_AW-1:0] rd_addr_a;
  logic [VREG_AW-1:0] rd_addr_b;
  logic [VLEN-1:0]    rd_data_a;
  logic [VLEN-1:0]    rd_data_b;
  logic               ex_valid;
  logic [VREG_AW-1:0] ex_vd;
  logic [VLEN-1:0]    ex_data;
  logic               ex_sat;
  logic               wb_en;
  logic [VREG_AW-1:0] wb_addr;
  logic [VLEN-1:0]    wb_data;

  rvv_uop_if u_uop_if ();

  assign inst_pkt.op  = inst_op_i;
  assign inst_pkt.vd  = inst_vd_i;
  assign inst_pkt.vs1 = inst_vs1_i;
  assign inst_pkt.vs2 = inst_vs2_i;
  assign inst_pkt.imm = inst_imm_i;

  rvv_cmd_queue u_cmd_queue (
    .clk          (clk),
    .rst_n        (rst_n),
    .push_valid_i (inst_valid_i),
    .push_ready_o (inst_ready_o),
    .push_inst_i  (inst_pkt),
    .head_valid_o (cmd_valid),
    .head_inst_o  (cmd_inst),
    .pop_i        (cmd_pop),
    .empty_o      (q_empty)
  );

  rvv_dispatch u_dispatch (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_valid_i (cmd_valid),
    .cmd_inst_i  (cmd_inst),
    .cmd_pop_o   (cmd_pop),
    .rd_addr_a_o (rd_addr_a),
    .rd_data_a_i (rd_data_a),
    .rd_addr_b_o (rd_addr_b),
    .rd_data_b_i (rd_data_b),
    .wb_en_i     (wb_en),
    .wb_addr_i   (wb_addr),
    .uop         (u_uop_if.issue),
    .busy_o      (dp_busy)
  );

  rvv_lane_alu u_lane_alu (
    .clk        (clk),
    .rst_n      (rst_n),
    .uop        (u_uop_if.exec),
    .ex_valid_o (ex_valid),
    .ex_vd_o    (ex_vd),
    .ex_data_o  (ex_data),
    .ex_sat_o   (ex_sat)
  );

  rvv_retire u_retire (
    .clk         (clk),
    .rst_n       (rst_n),
    .ex_valid_i  (ex_valid),
    .ex_vd_i     (ex_vd),
    .ex_data_i   (ex_data),
    .ex_sat_i    (ex_sat),
    .vxsat_clr_i (vxsat_clr_i),
    .wb_en_o     (wb_en),
    .wb_addr_o   (wb_addr),
    .wb_data_o   (wb_data),
    .rt_valid_o  (rt_valid_o),
    .rt_vd_o     (rt_vd_o),
    .rt_data_o   (rt_data_o),
    .vxsat_o     (vxsat_o)
  );

  rvv_vrf u_vrf (
    .clk         (clk),
    .rst_n       (rst_n),
    .wr_en_i     (wb_en),
    .wr_addr_i   (wb_addr),
    .wr_data_i   (wb_data),
    .rd_addr_a_i (rd_addr_a),
    .rd_data_a_o (rd_data_a),
    .rd_addr_b_i (rd_addr_b),
    .rd_data_b_o (rd_data_b)
  );

  // Scoreboard covers every uop from issue until writeback
  assign idle_o = q_empty && !dp_busy;

endmodule : rvv_backend

`default_nettype wire

// File: design/rvv_vrf.sv
`timescale 1ns/1ps
`default_nettype none

module rvv_vrf
  import rvv_cfg_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  input  logic               wr_en_i,
  input  logic [VREG_AW-1:0] wr_addr_i,
  input  logic [VLEN-1:0]    wr_data_i,
  input  logic [VREG_AW-1:0] rd_addr_a_i,
  output logic [VLEN-1:0]    rd_data_a_o,
  input  logic [VREG_AW-1:0] rd_addr_b_i,
  output logic [VLEN-1:0]    rd_data_b_o
);

  logic [VLEN-1:0] regs [NUM_VREG];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_VREG; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en_i) begin
      regs[wr_addr_i] <= wr_data_i;
    end
  end

  // Bypass write data to a same-cycle read
  assign rd_data_a_o = (wr_en_i && (wr_addr_i == rd_addr_a_i)) ? wr_data_i
                                                               : regs[rd_addr_a_i];
  assign rd_data_b_o = (wr_en_i && (wr_addr_i == rd_addr_b_i)) ? wr_data_i
                                                               : regs[rd_addr_b_i];

endmodule : rvv_vrf

`default_nettype wire

// File: design/rvv_retire.sv
`timescale 1ns/1ps
`default_nettype none

module rvv_retire
  import rvv_cfg_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  input  logic               ex_valid_i,
  input  logic [VREG_AW-1:0] ex_vd_i,
  input  logic [VLEN-1:0]    ex_data_i,
  input  logic               ex_sat_i,
  input  logic               vxsat_clr_i,
  output logic               wb_en_o,
  output logic [VREG_AW-1:0] wb_addr_o,
  output logic [VLEN-1:0]    wb_data_o,
  output logic               rt_valid_o,
  output logic [VREG_AW-1:0] rt_vd_o,
  output logic [VLEN-1:0]    rt_data_o,
  output logic               vxsat_o
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rt_valid_o <= 1'b0;
      vxsat_o    <= 1'b0;
    end else begin
      rt_valid_o <= ex_valid_i;
      // Saturating retire beats a clear in the same cycle
      if (ex_valid_i && ex_sat_i) begin
        vxsat_o <= 1'b1;
      end else if (vxsat_clr_i) begin
        vxsat_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid_i) begin
      rt_vd_o   <= ex_vd_i;
      rt_data_o <= ex_data_i;
    end
  end

  // Writeback and retire report share one register
  assign wb_en_o   = rt_valid_o;
  assign wb_addr_o = rt_vd_o;
  assign wb_data_o = rt_data_o;

endmodule : rvv_retire

`default_nettype wire

// File: design/rvv_lane_alu.sv
`timescale 1ns/1ps
`default_nettype none

module rvv_lane_alu
  import rvv_cfg_pkg::*, rvv_isa_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  rvv_uop_if.exec            uop,
  output logic               ex_valid_o,
  output logic [VREG_AW-1:0] ex_vd_o,
  output logic [VLEN-1:0]    ex_data_o,
  output logic               ex_sat_o
);

  logic                 s1_valid;
  logic [VREG_AW-1:0]   s1_vd;
  logic [VLEN-1:0]      s1_data;
  logic [NUM_LANES-1:0] s1_sat;
  logic [VLEN-1:0]      lane_res;
  logic [NUM_LANES-1:0] lane_sat;

  // Element ops, vs2 is the left operand as in vsub vd = vs2 - vs1
  always_comb begin : lane_calc
    logic [ELEN-1:0] a;
    logic [ELEN-1:0] b;
    logic [ELEN:0]   sum;
    logic [ELEN:0]   diff;
    lane_res = '0;
    lane_sat = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      a    = uop.src2[i*ELEN +: ELEN];
      b    = uop.src1[i*ELEN +: ELEN];
      sum  = {1'b0, a} + {1'b0, b};
      diff = {1'b0, a} - {1'b0, b};
      case (uop.op)
        OP_VMV_VI: lane_res[i*ELEN +: ELEN] = b;
        OP_VADD:   lane_res[i*ELEN +: ELEN] = sum[ELEN-1:0];
        OP_VSUB:   lane_res[i*ELEN +: ELEN] = diff[ELEN-1:0];
        OP_VAND:   lane_res[i*ELEN +: ELEN] = a & b;
        OP_VOR:    lane_res[i*ELEN +: ELEN] = a | b;
        OP_VXOR:   lane_res[i*ELEN +: ELEN] = a ^ b;
        OP_VSADDU: begin
          // Carry out means clamp to all ones
          lane_res[i*ELEN +: ELEN] = sum[ELEN] ? '1 : sum[ELEN-1:0];
          lane_sat[i]              = sum[ELEN];
        end
        OP_VSSUBU: begin
          // Borrow means clamp to zero
          lane_res[i*ELEN +: ELEN] = diff[ELEN] ? '0 : diff[ELEN-1:0];
          lane_sat[i]              = diff[ELEN];
        end
        default:   lane_res[i*ELEN +: ELEN] = '0;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid   <= 1'b0;
      ex_valid_o <= 1'b0;
    end else begin
      s1_valid   <= uop.uop_valid;
      ex_valid_o <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    s1_vd     <= uop.vd;
    s1_data   <= lane_res;
    s1_sat    <= lane_sat;
    ex_vd_o   <= s1_vd;
    ex_data_o <= s1_data;
    // Any clamped lane flags the whole uop
    ex_sat_o  <= |s1_sat;
  end

endmodule : rvv_lane_alu

`default_nettype wire

// File: design/rvv_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module rvv_dispatch
  import rvv_cfg_pkg::*, rvv_isa_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  input  logic               cmd_valid_i,
  input  rvv_inst_t          cmd_inst_i,
  output logic               cmd_pop_o,
  output logic [VREG_AW-1:0] rd_addr_a_o,
  input  logic [VLEN-1:0]    rd_data_a_i,
  output logic [VREG_AW-1:0] rd_addr_b_o,
  input  logic [VLEN-1:0]    rd_data_b_i,
  input  logic               wb_en_i,
  input  logic [VREG_AW-1:0] wb_addr_i,
  rvv_uop_if.issue           uop,
  output logic               busy_o
);

  // One pending-write bit per vector register
  logic [NUM_VREG-1:0] sb_q;
  logic [NUM_VREG-1:0] sb_clr;
  logic [NUM_VREG-1:0] sb_set;
  logic [NUM_VREG-1:0] sb_eff;
  logic                is_vmv;
  logic                hazard;
  logic                issue;
  logic [VLEN-1:0]     src1_sel;

  assign is_vmv = (cmd_inst_i.op == OP_VMV_VI);

  assign rd_addr_a_o = cmd_inst_i.vs1;
  assign rd_addr_b_o = cmd_inst_i.vs2;

  // Retiring register counts as free, the VRF forwards its write data
  assign sb_clr = wb_en_i ? (NUM_VREG'(1) << wb_addr_i) : '0;
  assign sb_eff = sb_q & ~sb_clr;

  // WAW/WAR on vd, RAW on sources unless immediate form
  assign hazard = sb_eff[cmd_inst_i.vd] ||
                  (!is_vmv && (sb_eff[cmd_inst_i.vs1] || sb_eff[cmd_inst_i.vs2]));
  assign issue     = cmd_valid_i && !hazard;
  assign cmd_pop_o = issue;

  assign sb_set   = issue ? (NUM_VREG'(1) << cmd_inst_i.vd) : '0;
  // Immediate broadcast into every lane
  assign src1_sel = is_vmv ? {NUM_LANES{cmd_inst_i.imm}} : rd_data_a_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sb_q          <= '0;
      uop.uop_valid <= 1'b0;
    end else begin
      sb_q          <= sb_eff | sb_set;
      uop.uop_valid <= issue;
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      uop.op   <= cmd_inst_i.op;
      uop.vd   <= cmd_inst_i.vd;
      uop.src1 <= src1_sel;
      uop.src2 <= rd_data_b_i;
    end
  end

  assign busy_o = (|sb_q) || uop.uop_valid;

endmodule : rvv_dispatch

`default_nettype wire

// File: design/rvv_cmd_queue.sv
`timescale 1ns/1ps
`default_nettype none

module rvv_cmd_queue
  import rvv_cfg_pkg::*, rvv_isa_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      push_valid_i,
  output logic      push_ready_o,
  input  rvv_inst_t push_inst_i,
  output logic      head_valid_o,
  output rvv_inst_t head_inst_o,
  input  logic      pop_i,
  output logic      empty_o
);

  rvv_inst_t          mem [CMDQ_DEPTH];
  logic [CMDQ_AW-1:0] wr_ptr;
  logic [CMDQ_AW-1:0] rd_ptr;
  logic [CMDQ_AW:0]   count;
  logic               full;
  logic               do_push;
  logic               do_pop;

  assign full    = (count == (CMDQ_AW+1)'(CMDQ_DEPTH));
  assign empty_o = (count == '0);
  assign do_pop  = pop_i && !empty_o;
  // A pop in the same cycle frees a slot for the incoming push
  assign push_ready_o = !full || do_pop;
  assign do_push      = push_valid_i && push_ready_o;

  assign head_valid_o = !empty_o;
  assign head_inst_o  = mem[rd_ptr];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap naturally at CMDQ_DEPTH
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= push_inst_i;
  end

endmodule : rvv_cmd_queue

`default_nettype wire

// File: design/rvv_uop_if.sv
`timescale 1ns/1ps
`default_nettype none

interface rvv_uop_if
  import rvv_cfg_pkg::*, rvv_isa_pkg::*;
();

  logic               uop_valid;
  rvv_op_e            op;
  logic [VREG_AW-1:0] vd;
  // src1 carries vs1 or the broadcast immediate, src2 carries vs2
  logic [VLEN-1:0]    src1;
  logic [VLEN-1:0]    src2;

  modport issue (
    output uop_valid, op, vd, src1, src2
  );

  modport exec (
    input uop_valid, op, vd, src1, src2
  );

endinterface : rvv_uop_if

`default_nettype wire

// File: design/rvv_isa_pkg.sv
`default_nettype none

package rvv_isa_pkg;

  import rvv_cfg_pkg::*;

  // Supported vector integer opcodes
  typedef enum logic [2:0] {
    OP_VMV_VI = 3'd0,
    OP_VADD   = 3'd1,
    OP_VSUB   = 3'd2,
    OP_VAND   = 3'd3,
    OP_VOR    = 3'd4,
    OP_VXOR   = 3'd5,
    OP_VSADDU = 3'd6,
    OP_VSSUBU = 3'd7
  } rvv_op_e;

  // One queued instruction, 20 bits
  typedef struct packed {
    rvv_op_e            op;
    logic [VREG_AW-1:0] vd;
    logic [VREG_AW-1:0] vs1;
    logic [VREG_AW-1:0] vs2;
    // Only used by vmv.v.i
    logic [ELEN-1:0]    imm;
  } rvv_inst_t;

endpackage : rvv_isa_pkg

`default_nettype wire

// File: design/rvv_cfg_pkg.sv
`default_nettype none

package rvv_cfg_pkg;

  // Vector register geometry
  localparam int VLEN      = 32;
  localparam int ELEN      = 8;
  localparam int NUM_LANES = VLEN / ELEN;

  // Register file
  localparam int NUM_VREG = 8;
  localparam int VREG_AW  = 3;

  // Command queue, depth must stay a power of two
  localparam int CMDQ_DEPTH = 4;
  localparam int CMDQ_AW    = 2;

endpackage : rvv_cfg_pkg

`default_nettype wire
